// ==== Makefile ====
TOP := cache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== bench/cache_asserts.sv ====
`default_nettype none

module cache_asserts (
    input wire                   CLK,
    input wire                   nRST,
    input wire                   ram_mem_REN,
    input wire                   ram_mem_WEN,
    input wire                   ram_mem_complete,
    input wire cache_pkg::addr_t ram_mem_addr,
    input wire                   scheduler_uuid_ready
);

    int violations = 0;

    strobes_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(ram_mem_REN && ram_mem_WEN))
    else begin
        violations++;
        $error("RAM read and write strobes are high together");
    end

    // A held request keeps its strobe and address until the RAM completes it
    request_held: assert property (@(posedge CLK) disable iff (!nRST)
        (ram_mem_REN || ram_mem_WEN) && !ram_mem_complete |=> $stable(ram_mem_addr)
        && $stable(ram_mem_REN) && $stable(ram_mem_WEN))
    else begin
        violations++;
        $error("RAM request changed before its complete pulse");
    end

    uuid_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        scheduler_uuid_ready |=> !scheduler_uuid_ready)
    else begin
        violations++;
        $error("scheduler_uuid_ready stayed high for more than one cycle");
    end

endmodule

bind cache_bank cache_asserts asserts_i (
    .CLK                  (CLK),
    .nRST                 (nRST),
    .ram_mem_REN          (ram_mem_REN),
    .ram_mem_WEN          (ram_mem_WEN),
    .ram_mem_complete     (ram_mem_complete),
    .ram_mem_addr         (ram_mem_addr),
    .scheduler_uuid_ready (scheduler_uuid_ready)
);

`default_nettype wire

// ==== bench/cache_tb.sv ====
`default_nettype none

module cache_tb;

    import cache_pkg::*;

    localparam int OPS         = 400;
    localparam int CYCLE_LIMIT = OPS * 60;
    localparam int MEM_WORDS   = 256;
    localparam int MSHR_DEPTH  = 4;

    logic   CLK, nRST;
    logic   instr_valid, rw_mode, halt;
    addr_t  instr_addr;
    word_t  store_value;
    uuid_t  instr_uuid;
    logic   scheduler_hit, scheduler_uuid_ready, mshr_full, cache_bank_busy, flushed;
    word_t  scheduler_data_out;
    uuid_t  scheduler_uuid_out;
    logic   ram_mem_REN, ram_mem_WEN, ram_mem_complete;
    addr_t  ram_mem_addr;
    word_t  ram_mem_store, ram_mem_data;

    word_t  ram_array [MEM_WORDS];
    word_t  ref_array [MEM_WORDS];
    int     ent_block [$]; // Block of each open miss entry, oldest first
    uuid_t  ent_uuid  [$];
    int     waiting   [$]; // Missed loads parked until their block returns
    int     retry     [$];
    integer seed;
    uuid_t  next_uuid;
    int     ram_wait, cycles, checks, errors, issued, merges, returns;

    lockup_free_cache dut_i (.*);

    initial begin : clock_gen
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin : watchdog
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the cache never drained or flushed", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Each strobe completes after one to three cycles, then the line drops for one cycle
    always @(posedge CLK) begin : ram_model
        #1;
        if (ram_mem_complete) begin
            ram_mem_complete = 1'b0;
        end else if (nRST && (ram_mem_REN || ram_mem_WEN)) begin
            if (ram_wait == 0) begin
                ram_mem_complete = 1'b1;
                ram_wait         = -1;
                if (ram_mem_WEN) ram_array[ram_mem_addr[9:2]] = ram_mem_store;
                else ram_mem_data = ram_array[ram_mem_addr[9:2]];
            end else begin
                ram_wait = ram_wait - 1;
            end
        end
    end

    // The delay of the next RAM access is drawn at the falling edge
    always @(negedge CLK) begin : ram_delay
        if (ram_wait < 0) ram_wait = int'($unsigned($random(seed)) % 3);
    end

    function automatic word_t fill_word(int idx);
        return (word_t'(idx) * 32'h9e37_79b1) ^ 32'h0bad_f00d;
    endfunction

    function automatic bit drained();
        return ent_block.size() == 0 && waiting.size() == 0 && retry.size() == 0;
    endfunction

    task automatic compare_word(string name, word_t expected, word_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic release_loads(int block);
        int keep [$];
        foreach (waiting[i]) begin
            if (waiting[i] / 4 == block) retry.push_back(waiting[i]);
            else keep.push_back(waiting[i]);
        end
        waiting = keep;
    endtask

    // A block whose entry heads the queue is held back until its uuid returns
    task automatic issue_request();
        int word;
        bit from_retry;
        instr_valid = 1'b0;
        if (mshr_full) return;
        from_retry = retry.size() > 0;
        if (from_retry) word = retry[0];
        else if (issued < OPS) word = int'($unsigned($random(seed)) % MEM_WORDS);
        else return;
        if (ent_block.size() > 0 && ent_block[0] == word / 4) return;
        if (from_retry) begin
            void'(retry.pop_front());
            rw_mode = 1'b0;
        end else begin
            issued++;
            rw_mode     = 1'($random(seed));
            store_value = $random(seed);
        end
        instr_addr  = addr_t'(word << 2);
        instr_uuid  = next_uuid;
        next_uuid   = next_uuid + 1'b1;
        instr_valid = 1'b1;
    endtask

    task automatic check_cycle();
        int word;
        bit merged;
        bit pending;
        compare_word("mshr_full", word_t'(ent_block.size() == MSHR_DEPTH), word_t'(mshr_full));
        compare_word("cache_bank_busy", word_t'(ent_block.size() > 0),
                     word_t'(cache_bank_busy));
        if (instr_valid) begin
            word = int'(instr_addr[9:2]);
            if (rw_mode) ref_array[word] = store_value; // Hit or miss, the store is accepted
            if (scheduler_hit) begin
                pending = 1'b0;
                foreach (ent_block[i]) begin
                    if (ent_block[i] == word / 4) pending = 1'b1;
                end
                checks++;
                assert (!pending) else begin
                    errors++;
                    $display("Block %0d hit while its miss was still outstanding", word / 4);
                end
            end
            if (scheduler_hit && !rw_mode) begin
                compare_word("load_hit", ref_array[word], scheduler_data_out);
            end
            if (!scheduler_hit) begin
                merged = 1'b0;
                for (int idx = 1; idx < ent_block.size(); idx++) begin
                    if (ent_block[idx] == word / 4) merged = 1'b1;
                end
                if (merged) begin
                    merges++;
                end else begin
                    ent_block.push_back(word / 4);
                    ent_uuid.push_back(instr_uuid);
                end
                if (!rw_mode) waiting.push_back(word);
            end
        end
        if (scheduler_uuid_ready) begin
            returns++;
            checks++;
            assert (ent_block.size() > 0) else begin
                errors++;
                $display("uuid %0d came back while no miss was outstanding",
                         scheduler_uuid_out);
            end
            if (ent_block.size() > 0) begin
                compare_word("uuid_return", word_t'(ent_uuid[0]), word_t'(scheduler_uuid_out));
                release_loads(ent_block[0]);
                void'(ent_block.pop_front());
                void'(ent_uuid.pop_front());
            end
        end
    endtask

    initial begin : stimulus
        int violations;
        seed             = 32'hc2c5;
        nRST             = 1'b0;
        instr_valid      = 1'b0;
        instr_addr       = '0;
        rw_mode          = 1'b0;
        store_value      = '0;
        instr_uuid       = '0;
        halt             = 1'b0;
        ram_mem_complete = 1'b0;
        ram_mem_data     = '0;
        ram_wait         = -1;
        next_uuid        = '0;
        cycles           = 0;
        checks           = 0;
        errors           = 0;
        issued           = 0;
        merges           = 0;
        returns          = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ram_array[i] = fill_word(i);
            ref_array[i] = ram_array[i];
        end
        repeat (10) @(posedge CLK);
        #1 nRST = 1'b1;
        while (issued < OPS || !drained()) begin
            @(posedge CLK);
            #1;
            issue_request();
            @(negedge CLK);
            check_cycle();
        end
        @(posedge CLK);
        #1;
        instr_valid = 1'b0;
        halt        = 1'b1;
        while (!flushed) @(negedge CLK); // Bounded by the watchdog
        compare_word("busy_after_flush", 32'd0, word_t'(cache_bank_busy));
        for (int i = 0; i < MEM_WORDS; i++) begin
            compare_word($sformatf("flush_ram[%0d]", i), ref_array[i], ram_array[i]);
        end
        violations = dut_i.bank_i.asserts_i.violations;
        $display("%0d checks, %0d errors, %0d assertion failures, %0d merges, %0d returns",
                 checks, errors, violations, merges, returns);
        if (errors == 0 && violations == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/cache_bank.sv ====
`default_nettype none

module cache_bank #(
    parameter  int NUM_WAYS   = 4,
    parameter  int NUM_SETS   = 8,
    parameter  int BLOCK_SIZE = 4,
    localparam int WAY_W      = $clog2(NUM_WAYS),
    localparam int SET_W      = $clog2(NUM_SETS),
    localparam int WORD_W     = $clog2(BLOCK_SIZE),
    localparam int TAG_W      = 30 - WORD_W - SET_W
) (
    input  wire                       CLK,
    input  wire                       nRST,
    input  wire                       instr_valid,
    input  wire cache_pkg::addr_t     instr_addr,
    input  wire                       rw_mode,
    input  wire cache_pkg::word_t     store_value,
    input  wire                       mshr_valid,
    input  wire cache_pkg::addr_t     mshr_block_addr,
    input  wire cache_pkg::uuid_t     mshr_uuid,
    input  wire [BLOCK_SIZE-1:0]      mshr_write_status,
    input  wire [BLOCK_SIZE*32-1:0]   mshr_write_block,
    input  wire cache_pkg::word_t     ram_mem_data,
    input  wire                       ram_mem_complete,
    input  wire                       halt,
    input  wire [WAY_W-1:0]           victim_way,
    output logic                      scheduler_hit,
    output cache_pkg::word_t          scheduler_data_out,
    output cache_pkg::uuid_t          scheduler_uuid_out,
    output logic                      scheduler_uuid_ready,
    output logic                      cache_bank_busy,
    output logic                      ram_mem_REN,
    output logic                      ram_mem_WEN,
    output cache_pkg::addr_t          ram_mem_addr,
    output cache_pkg::word_t          ram_mem_store,
    output logic                      flushed,
    output logic [SET_W-1:0]          victim_set,
    output logic                      touch_valid,
    output logic [SET_W-1:0]          touch_set,
    output logic [WAY_W-1:0]          touch_way
);

    import cache_pkg::*;

    logic [NUM_WAYS-1:0]    valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0]    dirty_q [NUM_SETS];
    logic [TAG_W-1:0]       tag_q   [NUM_SETS][NUM_WAYS];
    word_t [BLOCK_SIZE-1:0] data_q  [NUM_SETS][NUM_WAYS];

    bank_state_t            state, next_state;
    logic [WORD_W-1:0]      word_cnt;
    logic [SET_W-1:0]       flush_set;
    logic [WAY_W-1:0]       flush_way;
    logic                   advance, last_word, fl_dirty;

    logic [SET_W-1:0]       req_set, m_set, lat_set;
    logic [WORD_W-1:0]      req_word;
    logic [TAG_W-1:0]       req_tag, m_tag, lat_tag;
    logic [WAY_W-1:0]       hit_way, match_way, pick_way, lat_way;
    logic                   line_match, line_hit, lat_dirty, claim, store_hit;
    word_t [BLOCK_SIZE-1:0] old_line, new_line, pull_words;

    assign req_set    = SET_W'(addr_set(instr_addr, WORD_W, SET_W));
    assign req_word   = WORD_W'(addr_word(instr_addr, WORD_W));
    assign req_tag    = TAG_W'(addr_tag(instr_addr, WORD_W, SET_W));
    assign m_set      = SET_W'(addr_set(mshr_block_addr, WORD_W, SET_W));
    assign m_tag      = TAG_W'(addr_tag(mshr_block_addr, WORD_W, SET_W));
    assign pull_words = mshr_write_block;
    assign last_word  = word_cnt == WORD_W'(BLOCK_SIZE - 1);
    assign fl_dirty   = valid_q[flush_set][flush_way] && dirty_q[flush_set][flush_way];
    assign claim      = (state == START) && mshr_valid;
    assign pick_way   = line_match ? match_way : victim_way; // Reuse a way already holding the block

    // The way being claimed in START is hidden so a store cannot slip past the latched copy
    always_comb begin : tag_compare
        scheduler_hit = 1'b0;
        hit_way       = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (instr_valid && valid_q[req_set][i] && tag_q[req_set][i] == req_tag
                && !(claim && req_set == m_set && pick_way == WAY_W'(i))) begin
                scheduler_hit = 1'b1;
                hit_way       = WAY_W'(i);
            end
        end
    end

    always_comb begin : mshr_compare
        line_match = 1'b0;
        match_way  = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (valid_q[m_set][i] && tag_q[m_set][i] == m_tag) begin
                line_match = 1'b1;
                match_way  = WAY_W'(i);
            end
        end
    end

    assign scheduler_data_out = data_q[req_set][hit_way][req_word];
    assign store_hit          = scheduler_hit && rw_mode;
    assign victim_set         = m_set;
    assign touch_valid        = scheduler_hit || state == FINISH;
    assign touch_set          = scheduler_hit ? req_set : lat_set;
    assign touch_way          = scheduler_hit ? hit_way : lat_way;

    always_comb begin : control
        next_state           = state;
        advance              = 1'b0;
        cache_bank_busy      = 1'b1;
        ram_mem_REN          = 1'b0;
        ram_mem_WEN          = 1'b0;
        ram_mem_addr         = '0;
        ram_mem_store        = '0;
        scheduler_uuid_ready = 1'b0;
        scheduler_uuid_out   = '0;
        flushed              = 1'b0;
        case (state)
            START: begin
                cache_bank_busy = mshr_valid;
                if (mshr_valid) next_state = BLOCK_PULL;
                else if (halt) next_state = WRITEBACK;
            end
            BLOCK_PULL: begin
                if (mshr_write_status[word_cnt] || line_hit) begin
                    advance = 1'b1; // Word is already known, no RAM trip
                end else begin
                    ram_mem_REN  = 1'b1;
                    ram_mem_addr = make_addr(m_tag, lat_set, word_cnt, WORD_W, SET_W);
                    advance      = ram_mem_complete;
                end
                if (advance && last_word) begin
                    next_state = (lat_dirty && !line_hit) ? VICTIM_EJECT : FINISH;
                end
            end
            VICTIM_EJECT: begin
                ram_mem_WEN   = 1'b1;
                ram_mem_addr  = make_addr(lat_tag, lat_set, word_cnt, WORD_W, SET_W);
                ram_mem_store = old_line[word_cnt];
                advance       = ram_mem_complete;
                if (advance && last_word) next_state = FINISH;
            end
            FINISH: begin
                scheduler_uuid_ready = 1'b1;
                scheduler_uuid_out   = mshr_uuid;
                next_state           = START;
            end
            WRITEBACK: begin
                ram_mem_WEN   = fl_dirty;
                ram_mem_addr  = make_addr(tag_q[flush_set][flush_way], flush_set, word_cnt,
                                          WORD_W, SET_W);
                ram_mem_store = data_q[flush_set][flush_way][word_cnt];
                advance       = !fl_dirty || ram_mem_complete;
                if (advance && last_word && flush_set == SET_W'(NUM_SETS - 1)
                    && flush_way == WAY_W'(NUM_WAYS - 1)) begin
                    next_state = HALT;
                end
            end
            HALT: begin
                cache_bank_busy = 1'b0;
                flushed         = 1'b1;
            end
            default: next_state = START;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin : ctrl_regs
        if (!nRST) begin
            state     <= START;
            word_cnt  <= '0;
            flush_set <= '0;
            flush_way <= '0;
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            state <= next_state;
            if (advance) word_cnt <= word_cnt + 1'b1; // Wraps to zero after the last word
            if (store_hit) dirty_q[req_set][hit_way] <= 1'b1;
            if (claim) valid_q[m_set][pick_way] <= 1'b0;
            if (state == FINISH) begin
                valid_q[lat_set][lat_way] <= 1'b1;
                dirty_q[lat_set][lat_way] <= |mshr_write_status || (line_hit && lat_dirty);
            end
            if (state == WRITEBACK && advance && last_word) begin
                valid_q[flush_set][flush_way] <= 1'b0;
                dirty_q[flush_set][flush_way] <= 1'b0;
                flush_way                     <= flush_way + 1'b1;
                if (flush_way == WAY_W'(NUM_WAYS - 1)) flush_set <= flush_set + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin : line_regs
        if (store_hit) data_q[req_set][hit_way][req_word] <= store_value;
        if (claim) begin
            lat_set   <= m_set;
            lat_way   <= pick_way;
            lat_tag   <= tag_q[m_set][pick_way];
            lat_dirty <= valid_q[m_set][pick_way] && dirty_q[m_set][pick_way];
            line_hit  <= line_match;
            old_line  <= data_q[m_set][pick_way];
        end
        if (state == BLOCK_PULL && advance) begin
            new_line[word_cnt] <= mshr_write_status[word_cnt] ? pull_words[word_cnt]
                                : line_hit ? old_line[word_cnt] : ram_mem_data;
        end
        if (state == FINISH) begin
            tag_q[lat_set][lat_way]  <= m_tag;
            data_q[lat_set][lat_way] <= new_line;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    parameter int UUID_SIZE = 4;

    typedef logic [31:0]          addr_t;
    typedef logic [31:0]          word_t;
    typedef logic [UUID_SIZE-1:0] uuid_t;

    typedef enum logic [2:0] {
        START,
        BLOCK_PULL,
        VICTIM_EJECT,
        FINISH,
        WRITEBACK,
        HALT
    } bank_state_t;

    // Byte address layout from low to high is byte offset, word offset, set index, tag

    function automatic logic [31:0] addr_word(addr_t addr, int unsigned word_bits);
        return (addr >> 2) & ((32'd1 << word_bits) - 32'd1);
    endfunction

    function automatic logic [31:0] addr_set(addr_t addr, int unsigned word_bits,
                                             int unsigned set_bits);
        return (addr >> (2 + word_bits)) & ((32'd1 << set_bits) - 32'd1);
    endfunction

    function automatic logic [31:0] addr_tag(addr_t addr, int unsigned word_bits,
                                             int unsigned set_bits);
        return addr >> (2 + word_bits + set_bits);
    endfunction

    function automatic addr_t block_addr(addr_t addr, int unsigned word_bits);
        return addr & ~((32'd1 << (word_bits + 2)) - 32'd1); // Clears word and byte offset
    endfunction

    function automatic addr_t make_addr(logic [31:0] tag, logic [31:0] set,
                                        logic [31:0] word, int unsigned word_bits,
                                        int unsigned set_bits);
        return ((tag << (set_bits + word_bits)) | (set << word_bits) | word) << 2;
    endfunction

endpackage

`default_nettype wire

// ==== hw/lockup_free_cache.sv ====
`default_nettype none

module lockup_free_cache #(
    parameter  int NUM_WAYS   = 4,
    parameter  int NUM_SETS   = 8,
    parameter  int BLOCK_SIZE = 4,
    parameter  int MSHR_DEPTH = 4
) (
    input  wire                   CLK,
    input  wire                   nRST,
    input  wire                   instr_valid,
    input  wire cache_pkg::addr_t instr_addr,
    input  wire                   rw_mode,
    input  wire cache_pkg::word_t store_value,
    input  wire cache_pkg::uuid_t instr_uuid,
    input  wire                   halt,
    output logic                  scheduler_hit,
    output cache_pkg::word_t      scheduler_data_out,
    output cache_pkg::uuid_t      scheduler_uuid_out,
    output logic                  scheduler_uuid_ready,
    output logic                  mshr_full,
    output logic                  cache_bank_busy,
    output logic                  flushed,
    output logic                  ram_mem_REN,
    output logic                  ram_mem_WEN,
    output cache_pkg::addr_t      ram_mem_addr,
    output cache_pkg::word_t      ram_mem_store,
    input  wire cache_pkg::word_t ram_mem_data,
    input  wire                   ram_mem_complete
);

    import cache_pkg::*;

    logic                           mshr_valid;
    addr_t                          mshr_block_addr;
    uuid_t                          mshr_uuid;
    logic [BLOCK_SIZE-1:0]          mshr_write_status;
    logic [BLOCK_SIZE*32-1:0]       mshr_write_block;
    logic [$clog2(NUM_SETS)-1:0]    victim_set, touch_set;
    logic [$clog2(NUM_WAYS)-1:0]    victim_way, touch_way;
    logic                           touch_valid;

    cache_bank #(
        .NUM_WAYS   (NUM_WAYS),
        .NUM_SETS   (NUM_SETS),
        .BLOCK_SIZE (BLOCK_SIZE)
    ) bank_i (.*);

    mshr_buffer #(
        .BLOCK_SIZE (BLOCK_SIZE),
        .MSHR_DEPTH (MSHR_DEPTH)
    ) mshr_i (.*);

    plru_tree #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_SETS (NUM_SETS)
    ) lru_i (.*);

endmodule

`default_nettype wire

// ==== hw/mshr_buffer.sv ====
`default_nettype none

module mshr_buffer #(
    parameter  int BLOCK_SIZE = 4,
    parameter  int MSHR_DEPTH = 4,
    localparam int WORD_W     = $clog2(BLOCK_SIZE),
    localparam int PTR_W      = $clog2(MSHR_DEPTH)
) (
    input  wire                           CLK,
    input  wire                           nRST,
    input  wire                           instr_valid,
    input  wire                           scheduler_hit,
    input  wire cache_pkg::addr_t         instr_addr,
    input  wire                           rw_mode,
    input  wire cache_pkg::word_t         store_value,
    input  wire cache_pkg::uuid_t         instr_uuid,
    input  wire                           cache_bank_busy,
    input  wire                           scheduler_uuid_ready,
    output logic                          mshr_valid,
    output cache_pkg::addr_t              mshr_block_addr,
    output cache_pkg::uuid_t              mshr_uuid,
    output logic [BLOCK_SIZE-1:0]         mshr_write_status,
    output logic [BLOCK_SIZE*32-1:0]      mshr_write_block,
    output logic                          mshr_full
);

    import cache_pkg::*;

    logic [MSHR_DEPTH-1:0]   ent_valid;
    addr_t                   ent_addr   [MSHR_DEPTH];
    uuid_t                   ent_uuid   [MSHR_DEPTH];
    logic [BLOCK_SIZE-1:0]   ent_status [MSHR_DEPTH];
    word_t [BLOCK_SIZE-1:0]  ent_block  [MSHR_DEPTH];
    logic [PTR_W-1:0]        head, tail;

    addr_t                   req_block;
    logic [WORD_W-1:0]       req_word;
    logic                    accept;
    logic                    merge_hit;
    logic [PTR_W-1:0]        merge_idx;

    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(MSHR_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign req_block = block_addr(instr_addr, WORD_W);
    assign req_word  = WORD_W'(addr_word(instr_addr, WORD_W));
    assign accept    = instr_valid && !scheduler_hit;

    // The head is off limits once the bank has started pulling its block
    always_comb begin : find_merge
        merge_hit = 1'b0;
        merge_idx = '0;
        for (int i = 0; i < MSHR_DEPTH; i++) begin
            if (ent_valid[i] && ent_addr[i] == req_block
                && (PTR_W'(i) != head || !cache_bank_busy)) begin
                merge_hit = 1'b1;
                merge_idx = PTR_W'(i);
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin : queue_ctrl
        if (!nRST) begin
            ent_valid <= '0;
            head      <= '0;
            tail      <= '0;
        end else begin
            if (scheduler_uuid_ready) begin
                ent_valid[head] <= 1'b0;
                head            <= ptr_inc(head);
            end
            if (accept && !merge_hit && !mshr_full) begin
                ent_valid[tail] <= 1'b1;
                tail            <= ptr_inc(tail);
            end
        end
    end

    always_ff @(posedge CLK) begin : queue_payload
        if (accept && merge_hit) begin
            if (rw_mode) begin // A load only shares the entry
                ent_status[merge_idx][req_word] <= 1'b1;
                ent_block[merge_idx][req_word]  <= store_value;
            end
        end else if (accept && !mshr_full) begin
            ent_addr[tail]            <= req_block;
            ent_uuid[tail]            <= instr_uuid;
            ent_status[tail]          <= rw_mode ? (BLOCK_SIZE'(1) << req_word) : '0;
            ent_block[tail][req_word] <= store_value;
        end
    end

    assign mshr_valid        = ent_valid[head];
    assign mshr_block_addr   = ent_addr[head];
    assign mshr_uuid         = ent_uuid[head];
    assign mshr_write_status = ent_status[head];
    assign mshr_write_block  = ent_block[head];
    assign mshr_full         = &ent_valid;

endmodule

`default_nettype wire

// ==== hw/plru_tree.sv ====
`default_nettype none

module plru_tree #(
    parameter  int NUM_WAYS = 4,
    parameter  int NUM_SETS = 8,
    localparam int WAY_W    = $clog2(NUM_WAYS),
    localparam int SET_W    = $clog2(NUM_SETS)
) (
    input  wire              CLK,
    input  wire              nRST,
    input  wire  [SET_W-1:0] victim_set,
    input  wire              touch_valid,
    input  wire  [SET_W-1:0] touch_set,
    input  wire  [WAY_W-1:0] touch_way,
    output logic [WAY_W-1:0] victim_way
);

    logic [NUM_WAYS-2:0] tree [NUM_SETS]; // Node 0 is the root, children of n are 2n+1 and 2n+2
    logic [NUM_WAYS-2:0] touched_row;

    always_comb begin : walk_victim
        int node;
        node = 0;
        for (int lvl = 0; lvl < WAY_W; lvl++) begin
            victim_way[WAY_W-1-lvl] = tree[victim_set][node];
            node = 2 * node + 1 + int'(tree[victim_set][node]);
        end
    end

    always_comb begin : walk_touch
        int node;
        node = 0;
        touched_row = tree[touch_set];
        for (int lvl = 0; lvl < WAY_W; lvl++) begin
            touched_row[node] = ~touch_way[WAY_W-1-lvl]; // Point away from the used way
            node = 2 * node + 1 + int'(touch_way[WAY_W-1-lvl]);
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin : tree_update
        if (!nRST) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch_valid) begin
            tree[touch_set] <= touched_row;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
hw/cache_pkg.sv
hw/plru_tree.sv
hw/mshr_buffer.sv
hw/cache_bank.sv
hw/lockup_free_cache.sv
bench/cache_asserts.sv
bench/cache_tb.sv
